// File: hdl/regfile_cfg.svh
`ifndef REGFILE_CFG_SVH
`define REGFILE_CFG_SVH

// Bus geometry.
`define REG_ADDR_WIDTH 16
`define REG_DATA_WIDTH 32

// Interrupt and sample counter block.
`define REG_INTR_CNTL_OFS       16'h0000
`define REG_INTR_PER_OFS        16'h0004
`define REG_INTR_DUR_OFS        16'h0008
`define REG_SMPL_CNTL_OFS       16'h000c
`define REG_SMPL_CNTH_OFS       16'h0010
`define REG_INTR_CNT_OFS        16'h0014

// Code generator block.
`define REG_CODE_RATE_OFS       16'h0040
`define REG_CODE_PHASE_INIT_OFS 16'h0044
`define REG_CHIP_MAX_OFS        16'h0048
`define REG_CHIP_SYMB_INIT_OFS  16'h004c
`define REG_EPOCH_TOW_INIT_OFS  16'h0050
`define REG_EPOCH_SYMB_MAX_OFS  16'h0054
`define REG_CODE_PHASE_OFS      16'h0058
`define REG_CHIP_SYMB_OFS       16'h005c
`define REG_EPOCH_TOW_OFS       16'h0060

// Field widths.
`define INTR_PERIOD_WIDTH   32
`define INTR_DURATION_WIDTH 16
`define CHIP_WIDTH          24
`define EPOCH_WIDTH         10
`define TOW_WIDTH           20
`define SYMB_WIDTH          5

`define CHANNELS   8'd12
`define REGFILE_ID 8'hab

`endif

// File: hdl/regfile_pkg.sv
`include "regfile_cfg.svh"

package regfile_pkg;

    typedef enum logic [4:0] {
        SEL_INTR_CNTL,
        SEL_INTR_PER,
        SEL_INTR_DUR,
        SEL_SMPL_CNTL,
        SEL_SMPL_CNTH,
        SEL_INTR_CNT,
        SEL_CODE_RATE,
        SEL_CODE_PHASE_INIT,
        SEL_CHIP_MAX,
        SEL_CHIP_SYMB_INIT,
        SEL_EPOCH_TOW_INIT,
        SEL_EPOCH_SYMB_MAX,
        SEL_CODE_PHASE,
        SEL_CHIP_SYMB,
        SEL_EPOCH_TOW,
        SEL_NONE
    } reg_sel_t;

    typedef logic [`REG_DATA_WIDTH-1:0] reg_word_t;
    typedef logic [`CHIP_WIDTH-1:0]     chip_t;
    typedef logic [`EPOCH_WIDTH-1:0]    epoch_t;
    typedef logic [`TOW_WIDTH-1:0]      tow_t;
    typedef logic [`SYMB_WIDTH-1:0]     symb_t;

    typedef struct packed {
        logic [3:0]                       cntl;
        logic                             clksource;
        logic [2:0]                       extclk;
        logic [`INTR_PERIOD_WIDTH-1:0]    per;
        logic [`INTR_DURATION_WIDTH-1:0]  dur;
    } intr_view_t;

    typedef struct packed {
        chip_t  chip_max;
        epoch_t epoch_max;
        symb_t  symb_max;
    } code_view_t;

endpackage

// File: hdl/reg_bus_if.sv
interface reg_bus_if;

    logic                 wr;   // Write to a writable register.
    logic                 rd;
    regfile_pkg::reg_sel_t  sel;
    regfile_pkg::reg_word_t wdata;

    modport decode (
        output wr, rd, sel, wdata
    );

    modport bank (
        input wr, sel, wdata
    );

    modport readback (
        input rd, sel
    );

endinterface

// File: hdl/reg_decode.sv
`include "regfile_cfg.svh"

module reg_decode import regfile_pkg::*; (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       wr_en,
    input  logic                       rd_en,
    input  logic [`REG_ADDR_WIDTH-1:0] reg_addr,
    input  reg_word_t                  wdata,
    reg_bus_if.decode                  bus
);

    reg_sel_t sel;
    logic     writable;

    always_comb begin
        case (reg_addr)
            `REG_INTR_CNTL_OFS:       sel = SEL_INTR_CNTL;
            `REG_INTR_PER_OFS:        sel = SEL_INTR_PER;
            `REG_INTR_DUR_OFS:        sel = SEL_INTR_DUR;
            `REG_SMPL_CNTL_OFS:       sel = SEL_SMPL_CNTL;
            `REG_SMPL_CNTH_OFS:       sel = SEL_SMPL_CNTH;
            `REG_INTR_CNT_OFS:        sel = SEL_INTR_CNT;
            `REG_CODE_RATE_OFS:       sel = SEL_CODE_RATE;
            `REG_CODE_PHASE_INIT_OFS: sel = SEL_CODE_PHASE_INIT;
            `REG_CHIP_MAX_OFS:        sel = SEL_CHIP_MAX;
            `REG_CHIP_SYMB_INIT_OFS:  sel = SEL_CHIP_SYMB_INIT;
            `REG_EPOCH_TOW_INIT_OFS:  sel = SEL_EPOCH_TOW_INIT;
            `REG_EPOCH_SYMB_MAX_OFS:  sel = SEL_EPOCH_SYMB_MAX;
            `REG_CODE_PHASE_OFS:      sel = SEL_CODE_PHASE;
            `REG_CHIP_SYMB_OFS:       sel = SEL_CHIP_SYMB;
            `REG_EPOCH_TOW_OFS:       sel = SEL_EPOCH_TOW;
            default:                  sel = SEL_NONE;
        endcase
    end

    // Status words ignore writes.
    assign writable = (sel inside {SEL_INTR_CNTL, SEL_INTR_PER, SEL_INTR_DUR,
                                   SEL_CODE_RATE, SEL_CODE_PHASE_INIT, SEL_CHIP_MAX,
                                   SEL_CHIP_SYMB_INIT, SEL_EPOCH_TOW_INIT,
                                   SEL_EPOCH_SYMB_MAX});

    assign bus.wr    = wr_en & writable;
    assign bus.rd    = rd_en;
    assign bus.sel   = sel;
    assign bus.wdata = wdata;

    // The processor issues one access per cycle.
    a_no_wr_rd_overlap: assert property (
        @(posedge clk) disable iff (!reset_n) !(wr_en && rd_en)
    );

endmodule

// File: hdl/intr_ctrl_regs.sv
`include "regfile_cfg.svh"

module intr_ctrl_regs import regfile_pkg::*; (
    input  logic                           clk,
    input  logic                           reset_n,
    reg_bus_if.bank                        bus,
    output intr_view_t                     view,
    output logic [3:0]                     intr_cntl,
    output logic                           clksource,
    output logic [2:0]                     extclk,
    output logic                           intr_cntl_we,
    output logic [`INTR_PERIOD_WIDTH-1:0]  intr_per,
    output logic [`INTR_DURATION_WIDTH-1:0] intr_dur,
    output logic                           prog_reset,
    output logic                           ser_reset
);

    logic intr_cntl_wr;
    logic intr_per_wr;
    logic intr_dur_wr;
    logic prog_pulse;

    assign intr_cntl_wr = bus.wr && (bus.sel == SEL_INTR_CNTL);
    assign intr_per_wr  = bus.wr && (bus.sel == SEL_INTR_PER);
    assign intr_dur_wr  = bus.wr && (bus.sel == SEL_INTR_DUR);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            intr_cntl    <= 4'b0100;
            intr_cntl_we <= 1'b0;
            prog_pulse   <= 1'b0;
            ser_reset    <= 1'b0;
        end else begin
            if (intr_cntl_wr) begin
                intr_cntl <= bus.wdata[3:0];
            end else begin
                intr_cntl <= {1'b0, intr_cntl[2:0]};  // Bit 3 self-clears.
            end
            intr_cntl_we <= intr_cntl_wr;
            prog_pulse   <= intr_cntl_wr & bus.wdata[8];
            ser_reset    <= intr_cntl_wr & bus.wdata[9];
        end
    end

    assign prog_reset = ~prog_pulse;  // Active low.

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            clksource <= 1'b0;
            extclk    <= 3'b000;
            intr_per  <= '0;
            intr_dur  <= '0;
        end else begin
            if (intr_cntl_wr) begin
                clksource <= bus.wdata[4];
                extclk    <= bus.wdata[7:5];
            end
            if (intr_per_wr) begin
                intr_per <= bus.wdata[`INTR_PERIOD_WIDTH-1:0];
            end
            if (intr_dur_wr) begin
                intr_dur <= bus.wdata[`INTR_DURATION_WIDTH-1:0];
            end
        end
    end

    assign view = '{cntl: intr_cntl, clksource: clksource, extclk: extclk,
                    per: intr_per, dur: intr_dur};

    // Software resets are single-cycle pulses.
    a_prog_reset_pulse: assert property (
        @(posedge clk) disable iff (!reset_n) !prog_reset |=> prog_reset
    );

    a_ser_reset_pulse: assert property (
        @(posedge clk) disable iff (!reset_n) ser_reset |=> !ser_reset
    );

endmodule

// File: hdl/code_gen_regs.sv
module code_gen_regs import regfile_pkg::*; (
    input  logic       clk,
    input  logic       reset_n,
    reg_bus_if.bank    bus,
    output code_view_t view,
    output reg_word_t  code_rate,
    output reg_word_t  code_phase_init,
    output chip_t      chip_counter_init,
    output symb_t      symb_counter_init,
    output epoch_t     epoch_counter_init,
    output tow_t       tow_counter_init,
    output chip_t      chip_max,
    output epoch_t     epoch_max,
    output symb_t      symb_max,
    output logic       code_phase_init_wr,
    output logic       chip_and_symb_init_wr,
    output logic       epoch_and_tow_init_wr
);

    logic code_rate_wr;
    logic code_phase_wr;
    logic chip_symb_wr;
    logic epoch_tow_wr;
    logic chip_max_wr;
    logic epoch_symb_max_wr;

    assign code_rate_wr      = bus.wr && (bus.sel == SEL_CODE_RATE);
    assign code_phase_wr     = bus.wr && (bus.sel == SEL_CODE_PHASE_INIT);
    assign chip_symb_wr      = bus.wr && (bus.sel == SEL_CHIP_SYMB_INIT);
    assign epoch_tow_wr      = bus.wr && (bus.sel == SEL_EPOCH_TOW_INIT);
    assign chip_max_wr       = bus.wr && (bus.sel == SEL_CHIP_MAX);
    assign epoch_symb_max_wr = bus.wr && (bus.sel == SEL_EPOCH_SYMB_MAX);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            code_rate          <= '0;
            code_phase_init    <= '0;
            chip_counter_init  <= '0;
            symb_counter_init  <= '0;
            epoch_counter_init <= '0;
            tow_counter_init   <= '0;
            chip_max           <= '0;
            epoch_max          <= '0;
            symb_max           <= '0;
        end else begin
            if (code_rate_wr) begin
                code_rate <= bus.wdata;
            end
            if (code_phase_wr) begin
                code_phase_init <= bus.wdata;
            end
            if (chip_symb_wr) begin
                chip_counter_init <= bus.wdata[23:0];
                symb_counter_init <= bus.wdata[28:24];
            end
            if (epoch_tow_wr) begin
                epoch_counter_init <= bus.wdata[9:0];
                tow_counter_init   <= bus.wdata[29:10];
            end
            if (chip_max_wr) begin
                chip_max <= bus.wdata[23:0];
            end
            if (epoch_symb_max_wr) begin
                epoch_max <= bus.wdata[9:0];
                symb_max  <= bus.wdata[14:10];
            end
        end
    end

    // Strobes line up with the new init values.
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            code_phase_init_wr    <= 1'b0;
            chip_and_symb_init_wr <= 1'b0;
            epoch_and_tow_init_wr <= 1'b0;
        end else begin
            code_phase_init_wr    <= code_phase_wr;
            chip_and_symb_init_wr <= chip_symb_wr;
            epoch_and_tow_init_wr <= epoch_tow_wr;
        end
    end

    assign view = '{chip_max: chip_max, epoch_max: epoch_max, symb_max: symb_max};

    a_init_strobe_onehot: assert property (
        @(posedge clk) disable iff (!reset_n)
        $onehot0({code_phase_init_wr, chip_and_symb_init_wr, epoch_and_tow_init_wr})
    );

endmodule

// File: hdl/read_mux.sv
`include "regfile_cfg.svh"

module read_mux import regfile_pkg::*; (
    reg_bus_if.readback bus,
    input  intr_view_t  intr,
    input  code_view_t  code,
    input  reg_word_t   smpl_cntl,
    input  reg_word_t   smpl_cnth,
    input  reg_word_t   intr_cnt,
    input  reg_word_t   code_rate_int,
    input  reg_word_t   code_phase_int,
    input  chip_t       chip_int,
    input  symb_t       symb_int,
    input  epoch_t      epoch_int,
    input  tow_t        tow_int,
    output reg_word_t   rdata
);

    always_comb begin
        rdata = '0;
        if (bus.rd) begin
            case (bus.sel)
                SEL_INTR_CNTL: begin
                    rdata = {`REGFILE_ID, `CHANNELS, 8'h00, intr.extclk,
                             intr.clksource, 1'b0, intr.cntl[2:0]};
                end
                SEL_INTR_PER: begin
                    rdata = reg_word_t'(intr.per);
                end
                SEL_INTR_DUR: begin
                    rdata = reg_word_t'(intr.dur);
                end
                SEL_SMPL_CNTL: begin
                    rdata = smpl_cntl;
                end
                SEL_SMPL_CNTH: begin
                    rdata = smpl_cnth;
                end
                SEL_INTR_CNT: begin
                    rdata = intr_cnt;
                end
                SEL_CODE_RATE: begin
                    rdata = code_rate_int;  // Live rate, not the written one.
                end
                SEL_CHIP_MAX: begin
                    rdata = reg_word_t'(code.chip_max);
                end
                SEL_EPOCH_SYMB_MAX: begin
                    rdata = reg_word_t'({code.symb_max, code.epoch_max});
                end
                SEL_CODE_PHASE: begin
                    rdata = code_phase_int;
                end
                SEL_CHIP_SYMB: begin
                    rdata = reg_word_t'({symb_int, chip_int});
                end
                SEL_EPOCH_TOW: begin
                    rdata = reg_word_t'({tow_int, epoch_int});
                end
                default: begin
                    rdata = '0;  // Init words and unmapped.
                end
            endcase
        end
    end

endmodule

// File: hdl/common_regfile.sv
`include "regfile_cfg.svh"

module common_regfile import regfile_pkg::*; (
    input  logic                            clk,
    input  logic                            reset_n,
    input  logic                            wr_en,
    input  logic                            rd_en,
    input  logic [`REG_ADDR_WIDTH-1:0]      reg_addr,
    input  reg_word_t                       wdata,
    output reg_word_t                       rdata,
    input  reg_word_t                       smpl_cntl,
    input  reg_word_t                       smpl_cnth,
    input  reg_word_t                       intr_cnt,
    input  reg_word_t                       code_rate_int,
    input  reg_word_t                       code_phase_int,
    input  chip_t                           chip_int,
    input  symb_t                           symb_int,
    input  epoch_t                          epoch_int,
    input  tow_t                            tow_int,
    output logic [3:0]                      intr_cntl,
    output logic                            clksource,
    output logic [2:0]                      extclk,
    output logic                            intr_cntl_we,
    output logic [`INTR_PERIOD_WIDTH-1:0]   intr_per,
    output logic [`INTR_DURATION_WIDTH-1:0] intr_dur,
    output logic                            prog_reset,
    output logic                            ser_reset,
    output logic                            code_phase_init_wr,
    output logic                            chip_and_symb_init_wr,
    output logic                            epoch_and_tow_init_wr,
    output reg_word_t                       code_rate,
    output reg_word_t                       code_phase_init,
    output chip_t                           chip_counter_init,
    output chip_t                           chip_max,
    output epoch_t                          epoch_counter_init,
    output epoch_t                          epoch_max,
    output tow_t                            tow_counter_init,
    output symb_t                           symb_counter_init,
    output symb_t                           symb_max
);

    intr_view_t intr_view;
    code_view_t code_view;

    reg_bus_if bus ();

    reg_decode u_decode (
        .clk      (clk),
        .reset_n  (reset_n),
        .wr_en    (wr_en),
        .rd_en    (rd_en),
        .reg_addr (reg_addr),
        .wdata    (wdata),
        .bus      (bus.decode)
    );

    intr_ctrl_regs u_intr (
        .clk          (clk),
        .reset_n      (reset_n),
        .bus          (bus.bank),
        .view         (intr_view),
        .intr_cntl    (intr_cntl),
        .clksource    (clksource),
        .extclk       (extclk),
        .intr_cntl_we (intr_cntl_we),
        .intr_per     (intr_per),
        .intr_dur     (intr_dur),
        .prog_reset   (prog_reset),
        .ser_reset    (ser_reset)
    );

    code_gen_regs u_code (
        .clk                   (clk),
        .reset_n               (reset_n),
        .bus                   (bus.bank),
        .view                  (code_view),
        .code_rate             (code_rate),
        .code_phase_init       (code_phase_init),
        .chip_counter_init     (chip_counter_init),
        .symb_counter_init     (symb_counter_init),
        .epoch_counter_init    (epoch_counter_init),
        .tow_counter_init      (tow_counter_init),
        .chip_max              (chip_max),
        .epoch_max             (epoch_max),
        .symb_max              (symb_max),
        .code_phase_init_wr    (code_phase_init_wr),
        .chip_and_symb_init_wr (chip_and_symb_init_wr),
        .epoch_and_tow_init_wr (epoch_and_tow_init_wr)
    );

    read_mux u_rmux (
        .bus            (bus.readback),
        .intr           (intr_view),
        .code           (code_view),
        .smpl_cntl      (smpl_cntl),
        .smpl_cnth      (smpl_cnth),
        .intr_cnt       (intr_cnt),
        .code_rate_int  (code_rate_int),
        .code_phase_int (code_phase_int),
        .chip_int       (chip_int),
        .symb_int       (symb_int),
        .epoch_int      (epoch_int),
        .tow_int        (tow_int),
        .rdata          (rdata)
    );

endmodule

// File: sim/tb_common_regfile.sv
`include "regfile_cfg.svh"

module tb_common_regfile import regfile_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int unsigned TIMEOUT_CYCLES = 2000;

    logic                            clk;
    logic                            reset_n;
    logic                            wr_en;
    logic                            rd_en;
    logic [`REG_ADDR_WIDTH-1:0]      reg_addr;
    reg_word_t                       wdata;
    reg_word_t                       rdata;
    reg_word_t                       smpl_cntl;
    reg_word_t                       smpl_cnth;
    reg_word_t                       intr_cnt;
    reg_word_t                       code_rate_int;
    reg_word_t                       code_phase_int;
    chip_t                           chip_int;
    symb_t                           symb_int;
    epoch_t                          epoch_int;
    tow_t                            tow_int;
    logic [3:0]                      intr_cntl;
    logic                            clksource;
    logic [2:0]                      extclk;
    logic                            intr_cntl_we;
    logic [`INTR_PERIOD_WIDTH-1:0]   intr_per;
    logic [`INTR_DURATION_WIDTH-1:0] intr_dur;
    logic                            prog_reset;
    logic                            ser_reset;
    logic                            code_phase_init_wr;
    logic                            chip_and_symb_init_wr;
    logic                            epoch_and_tow_init_wr;
    reg_word_t                       code_rate;
    reg_word_t                       code_phase_init;
    chip_t                           chip_counter_init;
    chip_t                           chip_max;
    epoch_t                          epoch_counter_init;
    epoch_t                          epoch_max;
    tow_t                            tow_counter_init;
    symb_t                           symb_counter_init;
    symb_t                           symb_max;

    integer      seed = 32'hf73d;
    int unsigned cycles = 0;

    common_regfile dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            fail_run($sformatf("Timeout: the tests did not finish within %0d cycles",
                               TIMEOUT_CYCLES));
        end
    end

    task automatic fail_run(input string line);
        $display("%s", line);
        $display("Simulation failed");
        $fatal(1, "Stopped at the first error.");
    endtask

    function automatic reg_word_t rand_word();
        return $random(seed);
    endfunction

    // Interrupt control readback layout.
    function automatic reg_word_t cntl_word(input logic [2:0] ext, input logic src,
                                            input logic [2:0] bits);
        reg_word_t w;
        w = reg_word_t'(`REGFILE_ID) << 24;
        w = w | (reg_word_t'(`CHANNELS) << 16);
        w = w | (reg_word_t'(ext) << 5);
        w = w | (reg_word_t'(src) << 4);
        return w | reg_word_t'(bits);
    endfunction

    task automatic check_word(input string what, input reg_word_t got, input reg_word_t exp);
        if (got !== exp) begin
            fail_run($sformatf("FAILED at %0d ns: %s is 0x%08h, expected 0x%08h",
                               $time, what, got, exp));
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("FAILED at %0d ns: %s is %b, expected %b",
                               $time, what, got, exp));
        end
    endtask

    task automatic check_chip(input string what, input chip_t got, input chip_t exp);
        if (got !== exp) begin
            fail_run($sformatf("FAILED at %0d ns: %s is 0x%06h, expected 0x%06h",
                               $time, what, got, exp));
        end
    endtask

    task automatic check_symb(input string what, input symb_t got, input symb_t exp);
        if (got !== exp) begin
            fail_run($sformatf("FAILED at %0d ns: %s is %0d, expected %0d",
                               $time, what, got, exp));
        end
    endtask

    task automatic check_strobes(input logic [2:0] exp);
        check_flag("code_phase_init_wr", code_phase_init_wr, exp[2]);
        check_flag("chip_and_symb_init_wr", chip_and_symb_init_wr, exp[1]);
        check_flag("epoch_and_tow_init_wr", epoch_and_tow_init_wr, exp[0]);
    endtask

    // Returns on the falling edge right after the write edge.
    task automatic bus_write(input logic [`REG_ADDR_WIDTH-1:0] addr, input reg_word_t data);
        @(negedge clk);
        wr_en    = 1'b1;
        reg_addr = addr;
        wdata    = data;
        @(negedge clk);
        wr_en = 1'b0;
    endtask

    task automatic bus_read(input logic [`REG_ADDR_WIDTH-1:0] addr, output reg_word_t data);
        @(negedge clk);
        rd_en    = 1'b1;
        reg_addr = addr;
        #5;
        data = rdata;  // Mid low phase, well settled.
        @(negedge clk);
        rd_en = 1'b0;
    endtask

    task automatic read_expect(input logic [`REG_ADDR_WIDTH-1:0] addr, input reg_word_t exp,
                               input string what);
        reg_word_t data;
        bus_read(addr, data);
        check_word(what, data, exp);
    endtask

    task automatic test_reset_state();
        check_word("intr_cntl out", reg_word_t'(intr_cntl), 32'h4);
        check_flag("prog_reset", prog_reset, 1'b1);
        check_flag("ser_reset", ser_reset, 1'b0);
        check_flag("intr_cntl_we", intr_cntl_we, 1'b0);
        check_strobes(3'b000);
        read_expect(`REG_INTR_CNTL_OFS, cntl_word(3'b000, 1'b0, 3'b100), "intr control");
        read_expect(`REG_INTR_PER_OFS, 32'h0, "intr period");
        read_expect(`REG_INTR_DUR_OFS, 32'h0, "intr duration");
        read_expect(`REG_CODE_RATE_OFS, 32'h0, "code rate");
        read_expect(`REG_CODE_PHASE_INIT_OFS, 32'h0, "code phase init");
        read_expect(`REG_CHIP_MAX_OFS, 32'h0, "chip max");
        read_expect(`REG_CHIP_SYMB_INIT_OFS, 32'h0, "chip symbol init");
        read_expect(`REG_EPOCH_TOW_INIT_OFS, 32'h0, "epoch tow init");
        read_expect(`REG_EPOCH_SYMB_MAX_OFS, 32'h0, "epoch symbol max");
    endtask

    task automatic test_config_writes();
        reg_word_t d;
        repeat (4) begin
            d = rand_word();
            bus_write(`REG_INTR_PER_OFS, d);
            check_word("intr_per out", intr_per, d);
            read_expect(`REG_INTR_PER_OFS, d, "intr period");
            d = rand_word();
            bus_write(`REG_INTR_DUR_OFS, d);
            check_word("intr_dur out", reg_word_t'(intr_dur), {16'h0, d[15:0]});
            read_expect(`REG_INTR_DUR_OFS, {16'h0, d[15:0]}, "intr duration");
            d = rand_word();
            bus_write(`REG_CHIP_MAX_OFS, d);
            check_chip("chip_max out", chip_max, d[23:0]);
            read_expect(`REG_CHIP_MAX_OFS, {8'h0, d[23:0]}, "chip max");
            d = rand_word();
            bus_write(`REG_EPOCH_SYMB_MAX_OFS, d);
            check_word("epoch_max out", reg_word_t'(epoch_max), {22'h0, d[9:0]});
            check_symb("symb_max out", symb_max, d[14:10]);
            read_expect(`REG_EPOCH_SYMB_MAX_OFS, {17'h0, d[14:0]}, "epoch symbol max");
        end
    endtask

    task automatic test_intr_cntl();
        bus_write(`REG_INTR_CNTL_OFS, 32'h0000_03ba);  // Bits 3, 8 and 9 set.
        check_flag("intr_cntl_we", intr_cntl_we, 1'b1);
        check_word("intr_cntl out", reg_word_t'(intr_cntl), 32'ha);
        check_flag("prog_reset", prog_reset, 1'b0);
        check_flag("ser_reset", ser_reset, 1'b1);
        check_flag("clksource", clksource, 1'b1);
        check_word("extclk out", reg_word_t'(extclk), 32'h5);
        @(negedge clk);
        check_flag("intr_cntl_we", intr_cntl_we, 1'b0);
        check_word("intr_cntl out", reg_word_t'(intr_cntl), 32'h2);  // Bit 3 gone.
        check_flag("prog_reset", prog_reset, 1'b1);
        check_flag("ser_reset", ser_reset, 1'b0);
        check_flag("clksource", clksource, 1'b1);
        check_word("extclk out", reg_word_t'(extclk), 32'h5);
        read_expect(`REG_INTR_CNTL_OFS, cntl_word(3'b101, 1'b1, 3'b010), "intr control");
        bus_write(`REG_INTR_CNTL_OFS, 32'h0000_0005);
        check_flag("intr_cntl_we", intr_cntl_we, 1'b1);
        check_flag("prog_reset", prog_reset, 1'b1);
        check_flag("ser_reset", ser_reset, 1'b0);
        read_expect(`REG_INTR_CNTL_OFS, cntl_word(3'b000, 1'b0, 3'b101), "intr control");
    endtask

    task automatic test_init_strobes();
        reg_word_t d;
        d = rand_word();
        bus_write(`REG_CODE_PHASE_INIT_OFS, d);
        check_strobes(3'b100);
        check_word("code_phase_init out", code_phase_init, d);
        @(negedge clk);
        check_strobes(3'b000);
        d = rand_word();
        bus_write(`REG_CHIP_SYMB_INIT_OFS, d);
        check_strobes(3'b010);
        check_chip("chip_counter_init out", chip_counter_init, d[23:0]);
        check_symb("symb_counter_init out", symb_counter_init, d[28:24]);
        @(negedge clk);
        check_strobes(3'b000);
        d = rand_word();
        bus_write(`REG_EPOCH_TOW_INIT_OFS, d);
        check_strobes(3'b001);
        check_word("epoch_counter_init out", reg_word_t'(epoch_counter_init), {22'h0, d[9:0]});
        check_word("tow_counter_init out", reg_word_t'(tow_counter_init), {12'h0, d[29:10]});
        @(negedge clk);
        check_strobes(3'b000);
        d = rand_word();
        bus_write(`REG_CODE_RATE_OFS, d);
        check_strobes(3'b000);
        check_word("code_rate out", code_rate, d);
    endtask

    task automatic test_status_reads();
        reg_word_t d;
        @(negedge clk);
        smpl_cntl      = rand_word();
        smpl_cnth      = rand_word();
        intr_cnt       = rand_word();
        code_rate_int  = rand_word();
        code_phase_int = rand_word();
        d         = rand_word();
        chip_int  = d[23:0];
        symb_int  = d[28:24];
        d         = rand_word();
        epoch_int = d[9:0];
        tow_int   = d[29:10];
        read_expect(`REG_SMPL_CNTL_OFS, smpl_cntl, "sample count low");
        read_expect(`REG_SMPL_CNTH_OFS, smpl_cnth, "sample count high");
        read_expect(`REG_INTR_CNT_OFS, intr_cnt, "intr count");
        read_expect(`REG_CODE_RATE_OFS, code_rate_int, "live code rate");
        read_expect(`REG_CODE_PHASE_OFS, code_phase_int, "code phase");
        read_expect(`REG_CHIP_SYMB_OFS, {3'h0, symb_int, chip_int}, "chip symbol");
        read_expect(`REG_EPOCH_TOW_OFS, {2'h0, tow_int, epoch_int}, "epoch tow");
        read_expect(16'h0100, 32'h0, "unmapped address");
        read_expect(16'h0042, 32'h0, "misaligned address");
        @(negedge clk);
        reg_addr = `REG_SMPL_CNTL_OFS;
        #5;
        check_word("rdata with rd_en low", rdata, 32'h0);
    endtask

    initial begin
        reset_n        = 1'b0;
        wr_en          = 1'b0;
        rd_en          = 1'b0;
        reg_addr       = '0;
        wdata          = '0;
        smpl_cntl      = '0;
        smpl_cnth      = '0;
        intr_cnt       = '0;
        code_rate_int  = '0;
        code_phase_int = '0;
        chip_int       = '0;
        symb_int       = '0;
        epoch_int      = '0;
        tow_int        = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
        test_reset_state();
        test_config_writes();
        test_intr_cntl();
        test_init_strobes();
        test_status_reads();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// File: compile.f
+incdir+hdl
hdl/regfile_pkg.sv
hdl/reg_bus_if.sv
hdl/reg_decode.sv
hdl/intr_ctrl_regs.sv
hdl/code_gen_regs.sv
hdl/read_mux.sv
hdl/common_regfile.sv
sim/tb_common_regfile.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_common_regfile -f compile.f > build.log 2>&1 \
    || { cat build.log; echo "Build error"; exit 1; }
./obj_dir/Vtb_common_regfile > sim.log 2>&1
cat sim.log
grep -q "Simulation failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "Simulation completed successfully" sim.log && echo "PASS" \
    || { echo "FAIL: run ended without a result"; exit 1; }
